// File: Makefile
TOP := tb_tcdm_subsystem

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: list.f
tcdm_map_pkg.sv
tcdm_bus_pkg.sv
tcdm_id_fifo.sv
tcdm_arbiter.sv
tcdm_r_id_filter.sv
tcdm_sram_bank.sv
tcdm_subsystem_top.sv
tb_tcdm_subsystem.sv

// File: tb_tcdm_subsystem.sv
module tb_tcdm_subsystem
  import tcdm_map_pkg::*;
  import tcdm_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned WAIT_LIMIT = 64;

  logic                    clk_i;
  logic                    rst_ni;
  tcdm_req_t [N_PORTS-1:0] req;
  logic      [N_PORTS-1:0] rsp_ready;
  tcdm_rsp_t [N_PORTS-1:0] rsp;

  // reference copy of the bank.
  logic [DATA_W-1:0] ref_mem [BANK_WORDS];
  logic [31:0]       lfsr_q;

  tcdm_subsystem_top #(
    .MULTICYCLE_SUPPORT (1'b1),
    .N_OUTSTANDING      (2)
  ) i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req),
    .rsp_ready_i (rsp_ready),
    .rsp_o       (rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ******************************
  // helpers
  // ******************************

  // galois lfsr, one step per bit taken.
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hb4bc_d35c) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  // enabled bytes replaced, the rest kept.
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int unsigned b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // every byte depends on the full address.
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] add);
    return {add, ~add, add ^ 8'hc3, add + 8'h5d};
  endfunction

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("ERR @ %0t ns: %s: got 0x%08h, expected 0x%08h", $time, what, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "check failed");
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  // returns at the negedge of the grant cycle.
  task automatic wait_grant(input logic [ID_W-1:0] port);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (!rsp[port].gnt) begin
      n++;
      if (n > WAIT_LIMIT) begin
        $display("timeout waiting for grant");
        $display("SIMULATION FAILED");
        $fatal(1, "no grant on port %0d", port);
      end
      @(negedge clk_i);
    end
  endtask

  // lat counts the cycles past the one-cycle minimum.
  task automatic wait_response(input logic [ID_W-1:0] port, input bit shake_ready,
                               output int unsigned lat);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (!(rsp[port].r_valid && rsp_ready[port])) begin
      check_eq(32'(rsp[~port].r_valid), 32'd0, "r_valid on the idle port");
      n++;
      if (n > WAIT_LIMIT) begin
        $display("timeout waiting for response");
        $display("SIMULATION FAILED");
        $fatal(1, "no response on port %0d", port);
      end
      if (shake_ready) begin
        @(posedge clk_i);
        rsp_ready[port] <= (take_bits(2) != 32'd0);
      end
      @(negedge clk_i);
    end
    lat = n;
    check_eq(32'(rsp[port].r_id), 32'(port), "r_id of the response");
    check_eq(32'(rsp[~port].r_valid), 32'd0, "r_valid on the idle port");
  endtask

  // one request on one port, checked against the reference memory.
  task automatic transfer(input logic [ID_W-1:0] port, input logic wen,
                          input logic [ADDR_W-1:0] add, input logic [BE_W-1:0] be,
                          input logic [DATA_W-1:0] data, input bit shake_ready,
                          output int unsigned lat);
    tcdm_req_t         r;
    logic [DATA_W-1:0] exp_data;
    r      = '0;
    r.req  = 1'b1;
    r.add  = add;
    r.wen  = wen;
    r.be   = be;
    r.data = data;
    @(posedge clk_i);
    req[port] <= r;
    if (shake_ready) begin
      rsp_ready[port] <= (take_bits(2) != 32'd0);
    end
    wait_grant(port);
    @(posedge clk_i);
    req[port] <= '0;
    // a write acks with zero data.
    if (wen) begin
      exp_data = ref_mem[add];
    end else begin
      exp_data     = '0;
      ref_mem[add] = merge_bytes(ref_mem[add], data, be);
    end
    wait_response(port, shake_ready, lat);
    check_eq(rsp[port].r_data, exp_data, "r_data of the response");
  endtask

  // read response on one port, nothing on the other.
  task automatic expect_read_rsp(input logic [ID_W-1:0] port, input logic [ADDR_W-1:0] add);
    check_eq(32'(rsp[port].r_valid), 32'd1, "r_valid on the owning port");
    check_eq(32'(rsp[~port].r_valid), 32'd0, "r_valid on the other port");
    check_eq(32'(rsp[port].r_id), 32'(port), "r_id of the response");
    check_eq(rsp[port].r_data, ref_mem[add], "read data");
  endtask

  // ******************************
  // tests
  // ******************************

  task automatic preload_bank();
    int unsigned lat;
    for (int unsigned a = 0; a < BANK_WORDS; a++) begin
      transfer(ID_W'(a), 1'b0, ADDR_W'(a), '1, fill_word(ADDR_W'(a)), 1'b0, lat);
    end
  endtask

  task automatic test_write_read();
    int unsigned lat;
    transfer(1'b0, 1'b0, 8'h10, 4'hf, 32'hdead_beef, 1'b0, lat);
    check_eq(lat, 32'd0, "write latency");
    transfer(1'b0, 1'b1, 8'h10, 4'hf, 32'h0, 1'b0, lat);
    check_eq(lat, 32'd0, "read latency");
    check_eq(rsp[0].r_data, 32'hdead_beef, "read back of full word");
  endtask

  // partial writes pile up on one word.
  task automatic test_byte_enables();
    logic [BE_W-1:0] patterns [6] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0101, 4'b0000};
    int unsigned     lat;
    for (int unsigned i = 0; i < 6; i++) begin
      transfer(1'b0, 1'b0, 8'h24, patterns[i], take_bits(32), 1'b0, lat);
      transfer(1'b0, 1'b1, 8'h24, '0, '0, 1'b0, lat);
    end
  endtask

  // both ports busy, grants alternate from port 0.
  task automatic test_concurrent();
    tcdm_req_t         r [N_PORTS];
    logic [ADDR_W-1:0] prev_add;
    logic [ID_W-1:0]   exp_port;
    logic [ID_W-1:0]   prev_port;
    apply_reset();
    for (int unsigned k = 0; k < N_PORTS; k++) begin
      r[k]     = '0;
      r[k].req = 1'b1;
      r[k].wen = 1'b1;
      r[k].be  = '1;
      r[k].add = ADDR_W'(8'h40 + 8'h10 * k);
    end
    exp_port  = '0;
    prev_port = '0;
    prev_add  = '0;
    @(posedge clk_i);
    req[0] <= r[0];
    req[1] <= r[1];
    for (int unsigned i = 0; i < 6; i++) begin
      @(negedge clk_i);
      check_eq(32'(rsp[exp_port].gnt), 32'd1, "round-robin winner granted");
      check_eq(32'(rsp[~exp_port].gnt), 32'd0, "round-robin loser granted");
      if (i > 0) begin
        expect_read_rsp(prev_port, prev_add);
      end
      prev_port = exp_port;
      prev_add  = r[exp_port].add;
      @(posedge clk_i);
      // granted port moves on, the third grant is its last.
      r[exp_port].add = r[exp_port].add + 1'b1;
      r[exp_port].req = (i < 4);
      req[exp_port] <= r[exp_port];
      exp_port = ~exp_port;
    end
    @(negedge clk_i);
    expect_read_rsp(prev_port, prev_add);
    @(negedge clk_i);
    check_eq(32'(rsp[0].r_valid), 32'd0, "r_valid after the burst");
    check_eq(32'(rsp[1].r_valid), 32'd0, "r_valid after the burst");
  endtask

  task automatic test_backpressure();
    tcdm_req_t   r0;
    tcdm_req_t   r1;
    int unsigned lat;
    r1     = '0;
    r1.req = 1'b1;
    r1.wen = 1'b1;
    r1.be  = '1;
    r1.add = 8'h60;
    r0     = r1;
    r0.add = 8'h70;
    @(posedge clk_i);
    rsp_ready[1] <= 1'b0;
    req[1]       <= r1;
    wait_grant(1'b1);
    @(posedge clk_i);
    req[1] <= '0;
    req[0] <= r0;
    // held response, port 0 locked out.
    repeat (4) begin
      @(negedge clk_i);
      check_eq(32'(rsp[1].r_valid), 32'd1, "held r_valid");
      check_eq(rsp[1].r_data, ref_mem[8'h60], "held r_data");
      check_eq(32'(rsp[0].gnt), 32'd0, "grant while a response is held");
      check_eq(32'(rsp[0].r_valid), 32'd0, "r_valid on port 0 while held");
    end
    @(posedge clk_i);
    rsp_ready[1] <= 1'b1;
    @(negedge clk_i);
    expect_read_rsp(1'b1, 8'h60);
    check_eq(32'(rsp[0].gnt), 32'd1, "grant once ready rises");
    @(posedge clk_i);
    req[0] <= '0;
    @(negedge clk_i);
    expect_read_rsp(1'b0, 8'h70);
    // traffic after the stall.
    transfer(1'b1, 1'b0, 8'h61, 4'b1111, 32'hcafe_f00d, 1'b0, lat);
    check_eq(lat, 32'd0, "write latency after stall");
    transfer(1'b1, 1'b1, 8'h61, '0, '0, 1'b0, lat);
    check_eq(lat, 32'd0, "read latency after stall");
  endtask

  task automatic test_random();
    logic [ID_W-1:0]   port;
    logic              wen;
    logic [ADDR_W-1:0] add;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] data;
    int unsigned       lat;
    for (int unsigned n = 0; n < 200; n++) begin
      port = ID_W'(take_bits(1));
      wen  = 1'(take_bits(1));
      // narrow window so reads hit recent writes.
      add  = ADDR_W'(take_bits(5));
      be   = BE_W'(take_bits(BE_W));
      data = take_bits(DATA_W);
      transfer(port, wen, add, be, data, 1'b1, lat);
    end
    @(posedge clk_i);
    rsp_ready <= '1;
  endtask

  // ******************************
  // main sequence
  // ******************************

  initial begin
    rst_ni    = 1'b0;
    req       = '0;
    rsp_ready = '1;
    lfsr_q    = 32'hb19d_4d1e;
    apply_reset();
    preload_bank();
    test_write_read();
    test_byte_enables();
    test_concurrent();
    test_backpressure();
    test_random();
    @(posedge clk_i);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule : tb_tcdm_subsystem

// File: tcdm_arbiter.sv
module tcdm_arbiter
  import tcdm_map_pkg::*;
  import tcdm_bus_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  tcdm_req_t [N_PORTS-1:0]   req_i,
  input  logic      [N_PORTS-1:0]   rsp_ready_i,
  output tcdm_rsp_t [N_PORTS-1:0]   rsp_o,
  output tcdm_req_t                 down_req_o,
  output logic                      down_ready_o,
  input  tcdm_rsp_t                 down_rsp_i
);

  // first port the round-robin scan looks at.
  logic [ID_W-1:0]    rr_q;
  logic [ID_W-1:0]    sel_idx;
  logic               sel_valid;
  logic [N_PORTS-1:0] gnt_vec;
  logic [N_PORTS-1:0] req_vec;

  // ******************************
  // request selection
  // ******************************

  // scan ports starting at the pointer.
  always_comb begin
    int unsigned cand;
    sel_idx   = '0;
    sel_valid = 1'b0;
    for (int unsigned i = 0; i < N_PORTS; i++) begin
      cand = (int'(rr_q) + i) % N_PORTS;
      if (!sel_valid && req_i[cand].req) begin
        sel_valid = 1'b1;
        sel_idx   = ID_W'(cand);
      end
    end
  end

  // winner goes downstream tagged with its port.
  always_comb begin
    down_req_o     = req_i[sel_idx];
    down_req_o.req = sel_valid;
    down_req_o.id  = sel_idx;
  end

  // pointer moves past the granted port.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (sel_valid && down_rsp_i.gnt) begin
      rr_q <= (sel_idx == ID_W'(N_PORTS - 1)) ? '0 : sel_idx + 1'b1;
    end
  end

  // ******************************
  // response routing
  // ******************************

  // gnt goes to the winner only and the response follows r_id.
  for (genvar k = 0; k < N_PORTS; k++) begin : gen_port
    assign gnt_vec[k] = down_rsp_i.gnt && sel_valid && (sel_idx == ID_W'(k));
    assign req_vec[k] = req_i[k].req;

    always_comb begin
      rsp_o[k].gnt     = gnt_vec[k];
      rsp_o[k].r_valid = down_rsp_i.r_valid && (down_rsp_i.r_id == ID_W'(k));
      rsp_o[k].r_data  = down_rsp_i.r_data;
      rsp_o[k].r_id    = down_rsp_i.r_id;
    end

    // last winner yields to any other pending port.
    a_rr_fair: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ($past(gnt_vec[k]) && |(req_vec & ~(N_PORTS'(1) << k))) |-> !gnt_vec[k])
      else $error("round-robin winner granted again ahead of a waiting port");
  end

  // ready comes from the port that owns the response.
  assign down_ready_o = rsp_ready_i[down_rsp_i.r_id];

endmodule : tcdm_arbiter

// File: tcdm_bus_pkg.sv
package tcdm_bus_pkg;
  import tcdm_map_pkg::*;

  // ******************************
  // bus widths
  // ******************************

  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;
  localparam int unsigned ADDR_W = 8;

  // ******************************
  // request and response
  // ******************************

  // wen is high for a read, low for a write.
  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] add;
    logic              wen;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] data;
    logic [ID_W-1:0]   id;
  } tcdm_req_t;

  // r_id names the port the response belongs to.
  typedef struct packed {
    logic              gnt;
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
    logic [ID_W-1:0]   r_id;
  } tcdm_rsp_t;

endpackage : tcdm_bus_pkg

// File: tcdm_id_fifo.sv
module tcdm_id_fifo #(
  parameter int unsigned DEPTH = 2,
  parameter int unsigned WIDTH = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             push_i,
  input  logic             pop_i,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // head entry, valid one cycle after the push.
  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  // pointers and fill level.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keeps the level.
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // storage.
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // the caller must respect the flags.
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o || pop_i)
    else $error("id fifo pushed while full");

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o)
    else $error("id fifo popped while empty");

endmodule : tcdm_id_fifo

// File: tcdm_map_pkg.sv
package tcdm_map_pkg;

  // ******************************
  // bank geometry
  // ******************************

  // initiator ports sharing the bank.
  localparam int unsigned N_PORTS = 2;

  // one port index travels in the id field.
  localparam int unsigned ID_W = 1;

  // bank depth in 32-bit words.
  localparam int unsigned BANK_WORDS = 256;

  // word index into the bank array.
  localparam int unsigned IDX_W = $clog2(BANK_WORDS);

endpackage : tcdm_map_pkg

// File: tcdm_r_id_filter.sv
module tcdm_r_id_filter
  import tcdm_map_pkg::*;
  import tcdm_bus_pkg::*;
#(
  parameter bit          MULTICYCLE_SUPPORT = 1'b1,
  parameter int unsigned N_OUTSTANDING      = 2
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      enable_i,
  input  tcdm_req_t tgt_req_i,
  input  logic      tgt_ready_i,
  output tcdm_rsp_t tgt_rsp_o,
  output tcdm_req_t ini_req_o,
  output logic      ini_ready_o,
  input  tcdm_rsp_t ini_rsp_i
);

  // high while no further request can be tracked.
  logic            stall;
  logic [ID_W-1:0] r_id;

  // ******************************
  // shared passthrough
  // ******************************

  // id stripped toward the bank.
  always_comb begin
    ini_req_o     = tgt_req_i;
    ini_req_o.req = tgt_req_i.req && !stall;
    ini_req_o.id  = '0;
  end

  // id restored on the way back.
  always_comb begin
    tgt_rsp_o         = ini_rsp_i;
    tgt_rsp_o.gnt     = ini_rsp_i.gnt && !stall;
    tgt_rsp_o.r_id    = r_id;
  end

  assign ini_ready_o = tgt_ready_i;

  if (MULTICYCLE_SUPPORT) begin : gen_fifo_mode

    // ******************************
    // outstanding id queue
    // ******************************

    logic fifo_full;
    logic fifo_empty;
    logic fifo_push;
    logic fifo_pop;

    // push per grant, pop per accepted response.
    assign fifo_push = tgt_req_i.req && tgt_rsp_o.gnt;
    assign fifo_pop  = ini_rsp_i.r_valid && tgt_ready_i;
    assign stall     = fifo_full;

    tcdm_id_fifo #(
      .DEPTH (N_OUTSTANDING),
      .WIDTH (ID_W)
    ) i_id_fifo (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .flush_i (clear_i),
      .push_i  (fifo_push),
      .pop_i   (fifo_pop),
      .data_i  (tgt_req_i.id),
      .data_o  (r_id),
      .full_o  (fifo_full),
      .empty_o (fifo_empty)
    );

    // a response with nothing queued has lost its owner.
    a_rsp_has_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ini_rsp_i.r_valid |-> !fifo_empty)
      else $error("response without an outstanding id");

  end else begin : gen_reg_mode

    // ******************************
    // single id register
    // ******************************

    logic [ID_W-1:0] id_q;

    assign stall = 1'b0;
    assign r_id  = id_q;

    // last requester, valid for a response one cycle later.
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        id_q <= '0;
      end else if (clear_i) begin
        id_q <= '0;
      end else if (enable_i && tgt_req_i.req) begin
        id_q <= tgt_req_i.id;
      end
    end

    // only safe at the one-cycle latency boundary.
    a_read_rsp_next: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (ini_req_o.req && ini_rsp_i.gnt && ini_req_o.wen) |-> ##1 ini_rsp_i.r_valid)
      else $error("r_valid did not follow a read grant by one cycle");

    a_no_gnt_no_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(ini_req_o.req && ini_rsp_i.gnt) |-> ##1 !ini_rsp_i.r_valid)
      else $error("r_valid without a grant in the previous cycle");

  end

endmodule : tcdm_r_id_filter

// File: tcdm_sram_bank.sv
module tcdm_sram_bank
  import tcdm_map_pkg::*;
  import tcdm_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  tcdm_req_t req_i,
  input  logic      ready_i,
  output tcdm_rsp_t rsp_o
);

  logic [DATA_W-1:0] mem_q [BANK_WORDS];
  logic [IDX_W-1:0]  idx;
  logic              r_valid_q;
  logic [DATA_W-1:0] r_data_q;
  logic              hold;
  logic              gnt;

  assign idx = req_i.add[IDX_W-1:0];

  // response waiting for ready blocks new grants.
  assign hold = r_valid_q && !ready_i;
  assign gnt  = req_i.req && !hold;

  // ******************************
  // storage
  // ******************************

  // byte-enable write, untouched bytes keep their value.
  always_ff @(posedge clk_i) begin
    if (gnt && !req_i.wen) begin
      for (int unsigned b = 0; b < BE_W; b++) begin
        if (req_i.be[b]) begin
          mem_q[idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
        end
      end
    end
  end

  // ******************************
  // response register
  // ******************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else if (gnt) begin
      r_valid_q <= 1'b1;
    end else if (ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

  // read data, zero for a write ack.
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      r_data_q <= req_i.wen ? mem_q[idx] : '0;
    end
  end

  always_comb begin
    rsp_o.gnt     = gnt;
    rsp_o.r_valid = r_valid_q;
    rsp_o.r_data  = r_data_q;
    rsp_o.r_id    = '0;
  end

  // the filter upstream strips the port tag.
  a_id_stripped: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i.req |-> (req_i.id == '0))
    else $error("bank received a tagged request");

endmodule : tcdm_sram_bank

// File: tcdm_subsystem_top.sv
module tcdm_subsystem_top
  import tcdm_map_pkg::*;
  import tcdm_bus_pkg::*;
#(
  parameter bit          MULTICYCLE_SUPPORT = 1'b1,
  parameter int unsigned N_OUTSTANDING      = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  tcdm_req_t [N_PORTS-1:0] req_i,
  input  logic      [N_PORTS-1:0] rsp_ready_i,
  output tcdm_rsp_t [N_PORTS-1:0] rsp_o
);

  // arbiter to filter.
  tcdm_req_t arb_req;
  logic      arb_ready;
  tcdm_rsp_t arb_rsp;

  // filter to bank.
  tcdm_req_t bank_req;
  logic      bank_ready;
  tcdm_rsp_t bank_rsp;

  tcdm_arbiter i_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_o        (rsp_o),
    .down_req_o   (arb_req),
    .down_ready_o (arb_ready),
    .down_rsp_i   (arb_rsp)
  );

  // filter never cleared or paused here.
  tcdm_r_id_filter #(
    .MULTICYCLE_SUPPORT (MULTICYCLE_SUPPORT),
    .N_OUTSTANDING      (N_OUTSTANDING)
  ) i_r_id_filter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (1'b0),
    .enable_i    (1'b1),
    .tgt_req_i   (arb_req),
    .tgt_ready_i (arb_ready),
    .tgt_rsp_o   (arb_rsp),
    .ini_req_o   (bank_req),
    .ini_ready_o (bank_ready),
    .ini_rsp_i   (bank_rsp)
  );

  tcdm_sram_bank i_bank (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (bank_req),
    .ready_i (bank_ready),
    .rsp_o   (bank_rsp)
  );

endmodule : tcdm_subsystem_top
